//--- common/router_settings.svh
// Router settings
// Word layout, queue depth and flag thresholds shared by every block

`ifndef ROUTER_SETTINGS_SVH
`define ROUTER_SETTINGS_SVH

// Input word, class field on top
`define ROUTER_WORD_BITS 10
`define ROUTER_CLASS_BITS 2

// One queue per traffic class
`define ROUTER_NUM_CLASSES 4

// Queue depth as a power of two
`define ROUTER_DEPTH_LOG2 3
`define ROUTER_DEPTH (1 << `ROUTER_DEPTH_LOG2)

// Occupancy thresholds
`define ROUTER_ALMOST_FULL 6
`define ROUTER_ALMOST_EMPTY 3

`endif

//--- common/router_pkg.sv
// Router types
// Word, class, payload, occupancy and pointer types of the router

`include "router_settings.svh"

package router_pkg;

    // Traffic class, also the queue index
    typedef logic [`ROUTER_CLASS_BITS-1:0] class_t;

    // Low part of a word
    typedef logic [`ROUTER_WORD_BITS-`ROUTER_CLASS_BITS-1:0] payload_t;

    // Whole input word
    typedef struct packed {
        class_t   cls;
        payload_t payload;
    } word_t;

    // Occupancy from 0 up to the full depth
    typedef logic [`ROUTER_DEPTH_LOG2:0] count_t;

    // Read and write pointers
    typedef logic [`ROUTER_DEPTH_LOG2-1:0] ptr_t;

endpackage

//--- common/class_queue_if.sv
// Class queue interface
// Push side, pop side and status flags of one class queue

interface class_queue_if
    import router_pkg::*;
();

    // Writer side
    logic  push;
    word_t push_data;

    // Reader side
    logic  pop;
    word_t pop_data;

    // Status from the queue
    logic empty;
    logic almost_empty;
    logic almost_full;
    logic full;
    logic pause;
    logic error;

    modport writer (
        output push,
        output push_data
    );

    modport reader (
        output pop,
        input  pop_data,
        input  empty
    );

    modport queue (
        input  push,
        input  push_data,
        input  pop,
        output pop_data,
        output empty,
        output almost_empty,
        output almost_full,
        output full,
        output pause,
        output error
    );

endinterface

//--- fifo/queue_memory.sv
// Queue storage
// Small array written at the write pointer, read at the read pointer

`include "router_settings.svh"

module queue_memory
    import router_pkg::*;
(
    input  logic  clk,
    input  logic  write,
    input  ptr_t  wr_ptr,
    input  ptr_t  rd_ptr,
    input  word_t data_in,
    output word_t data_out
);

    word_t mem [`ROUTER_DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // Read port, the queue registers it on pop
    assign data_out = mem[rd_ptr];

endmodule

//--- fifo/class_fifo.sv
// Class FIFO
// One traffic class queue with occupancy count, status flags,
// pause level towards upstream and an error pulse on misuse

`include "router_settings.svh"

module class_fifo
    import router_pkg::*;
(
    input logic         clk,
    input logic         reset,
    class_queue_if.queue q
);

    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    count_t count;
    word_t  mem_out;
    word_t  pop_data_q;
    logic   do_push;
    logic   do_pop;

    // Pushes into a full queue are dropped
    assign do_push = q.push && !q.full;
    // Pops from an empty queue are ignored
    assign do_pop  = q.pop && !q.empty;

    queue_memory mem0 (
        .clk      (clk),
        .write    (do_push),
        .wr_ptr   (wr_ptr),
        .rd_ptr   (rd_ptr),
        .data_in  (q.push_data),
        .data_out (mem_out)
    );

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + ptr_t'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
            // Push and pop together leave the count alone
            if (do_push && !do_pop) begin
                count <= count + count_t'(1);
            end else if (do_pop && !do_push) begin
                count <= count - count_t'(1);
            end
        end
    end

    // Oldest word captured on every accepted pop
    always_ff @(posedge clk) begin
        if (do_pop) begin
            pop_data_q <= mem_out;
        end
    end

    assign q.pop_data = pop_data_q;

    // Flags straight from the count
    assign q.empty        = (count == '0);
    assign q.full         = (count == count_t'(`ROUTER_DEPTH));
    assign q.almost_full  = (count >= count_t'(`ROUTER_ALMOST_FULL));
    assign q.almost_empty = (count <= count_t'(`ROUTER_ALMOST_EMPTY)) && (count != '0);
    assign q.pause        = q.almost_full;

    // Overflow or underflow attempt flagged in the same cycle
    assign q.error = (q.push && q.full) || (q.pop && q.empty);

    // Occupancy stays within the array
    a_count_bound : assert property (
        @(posedge clk) disable iff (!reset)
        count <= count_t'(`ROUTER_DEPTH)
    );

    // Pointer distance tracks the occupancy
    a_ptr_count : assert property (
        @(posedge clk) disable iff (!reset)
        (wr_ptr - rd_ptr) == ptr_t'(count)
    );

endmodule

//--- src/class_decoder.sv
// Class decoder
// Registers each input word and pushes it into the queue of its class

module class_decoder
    import router_pkg::*;
(
    input logic           clk,
    input logic           reset,
    input logic           in_push,
    input word_t          in_word,
    class_queue_if.writer q0,
    class_queue_if.writer q1,
    class_queue_if.writer q2,
    class_queue_if.writer q3
);

    logic  valid_q;
    word_t word_q;

    // Input strobe
    always_ff @(posedge clk) begin
        if (!reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_push;
        end
    end

    // Word held for the push cycle
    always_ff @(posedge clk) begin
        if (in_push) begin
            word_q <= in_word;
        end
    end

    // Steer by the class field and let the queue judge overflow
    assign q0.push = valid_q && (word_q.cls == class_t'(0));
    assign q1.push = valid_q && (word_q.cls == class_t'(1));
    assign q2.push = valid_q && (word_q.cls == class_t'(2));
    assign q3.push = valid_q && (word_q.cls == class_t'(3));

    assign q0.push_data = word_q;
    assign q1.push_data = word_q;
    assign q2.push_data = word_q;
    assign q3.push_data = word_q;

    // Each input word reaches only its own class queue one cycle later
    a_push_steer : assert property (
        @(posedge clk) disable iff (!reset)
        in_push |=> ({q3.push, q2.push, q1.push, q0.push} == (4'b0001 << $past(in_word.cls)))
    );

endmodule

//--- src/rr_drain.sv
// Round-robin drain
// Pops the next nonempty class queue after the last one served and
// presents its word on the output, holding off during stall

`include "router_settings.svh"

module rr_drain
    import router_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          out_stall,
    class_queue_if.reader q0,
    class_queue_if.reader q1,
    class_queue_if.reader q2,
    class_queue_if.reader q3,
    output logic          out_valid,
    output word_t         out_word
);

    logic [`ROUTER_NUM_CLASSES-1:0] req;
    logic [`ROUTER_NUM_CLASSES-1:0] pop_vec;
    class_t last_q;
    class_t sel_q;
    class_t pick;
    class_t cand;
    logic   found;
    logic   grant;
    logic   valid_q;

    assign req = {!q3.empty, !q2.empty, !q1.empty, !q0.empty};

    // First nonempty class after the last served one, with wraparound
    always_comb begin
        pick  = last_q;
        cand  = last_q;
        found = 1'b0;
        for (int i = 1; i <= `ROUTER_NUM_CLASSES; i++) begin
            cand = last_q + class_t'(i);
            if (!found && req[cand]) begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    assign grant = found && !out_stall;

    // One pop strobe per class
    always_comb begin
        pop_vec = '0;
        if (grant) begin
            pop_vec[pick] = 1'b1;
        end
    end

    assign q0.pop = pop_vec[0];
    assign q1.pop = pop_vec[1];
    assign q2.pop = pop_vec[2];
    assign q3.pop = pop_vec[3];

    // Last served starts at 3 so class 0 goes first
    always_ff @(posedge clk) begin
        if (!reset) begin
            last_q  <= class_t'(`ROUTER_NUM_CLASSES - 1);
            valid_q <= 1'b0;
        end else begin
            valid_q <= grant;
            if (grant) begin
                last_q <= pick;
            end
        end
    end

    // Remember which queue to show next cycle
    always_ff @(posedge clk) begin
        if (grant) begin
            sel_q <= pick;
        end
    end

    assign out_valid = valid_q;

    always_comb begin
        case (sel_q)
            class_t'(0): out_word = q0.pop_data;
            class_t'(1): out_word = q1.pop_data;
            class_t'(2): out_word = q2.pop_data;
            default:     out_word = q3.pop_data;
        endcase
    end

    // The class just served wins again only when no other class waits
    a_rr_fair : assert property (
        @(posedge clk) disable iff (!reset)
        (grant && (pick == last_q)) |-> (req == pop_vec)
    );

endmodule

//--- src/class_router.sv
// Four-class packet router
// Decodes words into per-class FIFOs and drains them round-robin
// onto a single output port

module class_router
    import router_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  in_push,
    input  word_t in_word,
    output logic  pause,
    input  logic  out_stall,
    output logic  out_valid,
    output word_t out_word,
    output logic  error
);

    class_queue_if q0 ();
    class_queue_if q1 ();
    class_queue_if q2 ();
    class_queue_if q3 ();

    // Decode stage
    class_decoder decoder0 (
        .clk     (clk),
        .reset   (reset),
        .in_push (in_push),
        .in_word (in_word),
        .q0      (q0.writer),
        .q1      (q1.writer),
        .q2      (q2.writer),
        .q3      (q3.writer)
    );

    // Class queues
    class_fifo fifo0 (
        .clk   (clk),
        .reset (reset),
        .q     (q0.queue)
    );

    class_fifo fifo1 (
        .clk   (clk),
        .reset (reset),
        .q     (q1.queue)
    );

    class_fifo fifo2 (
        .clk   (clk),
        .reset (reset),
        .q     (q2.queue)
    );

    class_fifo fifo3 (
        .clk   (clk),
        .reset (reset),
        .q     (q3.queue)
    );

    // Result stage
    rr_drain drain0 (
        .clk       (clk),
        .reset     (reset),
        .out_stall (out_stall),
        .q0        (q0.reader),
        .q1        (q1.reader),
        .q2        (q2.reader),
        .q3        (q3.reader),
        .out_valid (out_valid),
        .out_word  (out_word)
    );

    // Any queue near full holds upstream off
    assign pause = q0.pause | q1.pause | q2.pause | q3.pause;
    assign error = q0.error | q1.error | q2.error | q3.error;

endmodule

//--- verification/tb_class_router.sv
// Class router testbench
// Table-driven phases against a cycle model of decoder, class queues and drain

`include "router_settings.svh"

module tb_class_router
    import router_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_CLASSES = `ROUTER_NUM_CLASSES;
    localparam int DEPTH       = `ROUTER_DEPTH;
    localparam int PAUSE_LEVEL = `ROUTER_ALMOST_FULL;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES = 20;
    localparam int DRAIN_SLACK = 64;
    localparam int NUM_ROWS    = 9;

    typedef enum logic [1:0] {PAT_IDLE, PAT_FIXED, PAT_CYCLE, PAT_RANDOM} pattern_t;

    // One phase as word slots, class pattern, cycles per slot and stall level
    typedef struct packed {
        int       words;
        pattern_t pattern;
        class_t   cls;
        int       gap;
        logic     stall;
    } phase_t;

    localparam phase_t PHASES [NUM_ROWS] = '{
        '{12, PAT_CYCLE,  2'd0, 1, 1'b0},  // steady traffic over all classes
        '{9,  PAT_FIXED,  2'd0, 1, 1'b1},  // ninth word overflows class 0
        '{4,  PAT_IDLE,   2'd0, 1, 1'b1},  // last pushes land while still stalled
        '{16, PAT_IDLE,   2'd0, 1, 1'b0},  // eight class 0 words come out after release
        '{16, PAT_CYCLE,  2'd0, 1, 1'b1},  // four words in every queue
        '{24, PAT_IDLE,   2'd0, 1, 1'b0},  // round-robin drain
        '{40, PAT_RANDOM, 2'd0, 2, 1'b0},
        '{30, PAT_RANDOM, 2'd0, 1, 1'b1},  // pause and overflow under stall
        '{40, PAT_RANDOM, 2'd0, 1, 1'b0}
    };

    logic  clk = 1'b0;
    logic  reset;
    logic  in_push;
    word_t in_word;
    logic  pause;
    logic  out_stall;
    logic  out_valid;
    word_t out_word;
    logic  error;

    // Model of the router state after the latest edge
    word_t       model_q [NUM_CLASSES][$];
    logic        dec_valid;
    word_t       dec_word;
    logic        pend_valid;
    word_t       pend_word;
    class_t      pend_cls;
    class_t      last_cls;
    int          seq;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    logic [31:0] rng;

    class_router dut0 (
        .clk       (clk),
        .reset     (reset),
        .in_push   (in_push),
        .in_word   (in_word),
        .pause     (pause),
        .out_stall (out_stall),
        .out_valid (out_valid),
        .out_word  (out_word),
        .error     (error)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            fail_run($sformatf("Timeout after %0d cycles, the router did not drain",
                               cycle_count));
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int total_phase_cycles();
        int total;
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += PHASES[r].words * PHASES[r].gap;
        end
        return total;
    endfunction

    function automatic logic model_busy();
        logic busy;
        busy = dec_valid || pend_valid;
        for (int c = 0; c < NUM_CLASSES; c++) begin
            if (model_q[c].size() > 0) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_class(input string name, input class_t got, input class_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    // Called 5 ns after an edge; samples at 45 ns, returns 5 ns after the next edge
    task automatic run_cycle(input logic push, input word_t word, input logic stall);
        logic exp_pause;
        logic exp_error;
        logic accept;
        int   c;
        in_push   = push;
        in_word   = word;
        out_stall = stall;
        #40;
        exp_pause = 1'b0;
        for (int k = 0; k < NUM_CLASSES; k++) begin
            if (model_q[k].size() >= PAUSE_LEVEL) begin
                exp_pause = 1'b1;
            end
        end
        exp_error = dec_valid && (model_q[dec_word.cls].size() == DEPTH);
        check_flag("out_valid", out_valid, pend_valid);
        if (pend_valid) begin
            check_class("out_word.cls", out_word.cls, pend_cls);
            check_word("out_word", out_word, pend_word);
        end
        check_flag("error", error, exp_error);
        check_flag("pause", pause, exp_pause);

        // Full is judged before this edge's pop
        accept = dec_valid && (model_q[dec_word.cls].size() < DEPTH);
        pend_valid = 1'b0;
        if (!stall) begin
            for (int i = 1; i <= NUM_CLASSES; i++) begin
                c = (int'(last_cls) + i) % NUM_CLASSES;
                if (!pend_valid && model_q[c].size() > 0) begin
                    pend_valid = 1'b1;
                    pend_cls   = class_t'(c);
                    pend_word  = model_q[c].pop_front();
                    last_cls   = class_t'(c);
                end
            end
        end
        if (accept) begin
            model_q[dec_word.cls].push_back(dec_word);
        end
        dec_valid = push;
        dec_word  = word;
        @(posedge clk);
        #5;
    endtask

    task automatic run_phase(input phase_t ph);
        word_t  w;
        class_t c;
        logic   push;
        for (int n = 0; n < ph.words; n++) begin
            case (ph.pattern)
                PAT_FIXED: c = ph.cls;
                PAT_CYCLE: c = class_t'(n % NUM_CLASSES);
                PAT_RANDOM: begin
                    rng = xorshift32(rng);
                    c   = rng[9:8];
                end
                default: c = class_t'(0);
            endcase
            w.cls     = c;
            w.payload = payload_t'(seq);
            for (int g = 0; g < ph.gap; g++) begin
                push = (g == 0) && (ph.pattern != PAT_IDLE);
                run_cycle(push, w, ph.stall);
                if (push) begin
                    seq++;
                end
            end
        end
    endtask

    initial begin
        reset      = 1'b0;
        in_push    = 1'b0;
        in_word    = '0;
        out_stall  = 1'b0;
        dec_valid  = 1'b0;
        dec_word   = '0;
        pend_valid = 1'b0;
        pend_word  = '0;
        pend_cls   = '0;
        last_cls   = class_t'(NUM_CLASSES - 1);
        seq        = 0;
        rng        = 32'hec9c9883;
        cycle_limit = RESET_CYCLES + IDLE_CYCLES + total_phase_cycles() + DRAIN_SLACK;

        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        reset = 1'b1;

        // Quiet router gives no output without input
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            run_cycle(1'b0, '0, 1'b0);
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_phase(PHASES[r]);
        end

        // Drain whatever the queues still hold
        while (model_busy()) begin
            run_cycle(1'b0, '0, 1'b0);
        end
        repeat (5) run_cycle(1'b0, '0, 1'b0);

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+common
common/router_pkg.sv
common/class_queue_if.sv
fifo/queue_memory.sv
fifo/class_fifo.sv
src/class_decoder.sv
src/rr_drain.sv
src/class_router.sv
verification/tb_class_router.sv

//--- Makefile
# Verilator build and run of the class router testbench

VERILATOR ?= verilator
TOP       ?= tb_class_router
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	rm -f $(LOG)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '^>>> PASS$$' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
